// ==== mvsPkg.sv ====
package mvsPkg;

	// 68000 word address, A23 down to A1
	typedef logic [22:0] m68kAddr_t;

	// One 16-bit bus word
	typedef logic [15:0] m68kData_t;

	// CPU port longword address, A23 down to A2
	typedef logic [21:0] cpuAddr_t;

	// One 68000 bus cycle as seen by the I/O chips
	typedef struct packed {
		logic valid;
		m68kAddr_t addr;
		m68kData_t wrData;
		// High for a read, as on the real RW pin
		logic rw;
		// Byte lanes, active high here
		logic uds;
		logic lds;
	} busCycle_t;

	// Single-cycle write strobes out of the decoder
	typedef struct packed {
		logic pOutput;
		logic crdBank;
		logic slot;
		logic ledLatch;
		logic ledData;
		logic coinLatch;
		logic sysLatch;
	} ioStrobe_t;

	// Read select for the port mux
	typedef enum logic [2:0] {
		regP1Dip,
		regStatusA,
		regP2,
		regStatusB,
		regNone
	} ioRegion_t;

	// System latch, shadow sits at bit 0
	typedef struct packed {
		logic palBank;
		logic nSramLock;
		logic nSystem;
		logic nRegEn;
		logic cardWenB;
		logic nCardWen;
		logic nVec;
		logic shadow;
	} sysLatch_t;

	// Coin counters and lockouts, counter1 at bit 0
	typedef struct packed {
		logic lockout2;
		logic lockout1;
		logic counter2;
		logic counter1;
	} coinCtl_t;

	// Adapter sequencing
	typedef enum logic [1:0] {
		idle,
		hiWord,
		loWord,
		done
	} adapterState_t;

	// Byte address bits 23 to 17 of each I/O area
	localparam logic [6:0] regionIo0 = 7'h18;
	localparam logic [6:0] regionIo1 = 7'h19;
	localparam logic [6:0] regionIo2 = 7'h1A;
	localparam logic [6:0] regionIo4 = 7'h1C;
	localparam logic [6:0] regionIo5 = 7'h1D;

endpackage

// ==== neoBitLatch.sv ====
`timescale 1ns/1ns

module neoBitLatch #(
	parameter int numBits = 8
) (
	input logic clk68k,
	input logic rstN,
	input logic wrStb,
	input mvsPkg::m68kAddr_t addr,
	output logic [numBits-1:0] q
);

	// Select bits needed for the latch width
	localparam int selBits = $clog2(numBits);

	// Byte bits from A1 up pick the bit, A4 is the value
	always_ff @(posedge clk68k)
	begin
		if (!rstN)
			q <= '0;
		else if (wrStb)
			q[addr[selBits-1:0]] <= addr[3];
	end

endmodule

// ==== neoAddrDecode.sv ====
`timescale 1ns/1ns

module neoAddrDecode (
	input mvsPkg::busCycle_t bus,
	output mvsPkg::ioStrobe_t strobe,
	output mvsPkg::ioRegion_t region
);

	logic [6:0] regionSel;
	logic [2:0] subSel;
	logic wrLow;
	logic inBitW0;
	logic inBitW1;

	// Byte bits 23 to 17 pick the area
	assign regionSel = bus.addr[22:16];
	// Byte bits 6 to 4 pick the target inside 0x38
	assign subSel = bus.addr[5:3];

	// Only lower lane writes reach the I/O latches
	assign wrLow = bus.valid & ~bus.rw & bus.lds;
	assign inBitW0 = wrLow & (regionSel == mvsPkg::regionIo4);
	assign inBitW1 = wrLow & (regionSel == mvsPkg::regionIo5);

	// Write strobes
	always_comb
	begin
		strobe = '0;
		if (inBitW0)
		begin
			case (subSel)
				3'b000: strobe.pOutput = 1'b1;
				3'b001: strobe.crdBank = 1'b1;
				3'b010: strobe.slot = 1'b1;
				3'b011: strobe.ledLatch = 1'b1;
				3'b100: strobe.ledData = 1'b1;
				// 0x380061 up to 0x38007F is the coin block
				3'b110,
				3'b111: strobe.coinLatch = 1'b1;
				default:
				begin
				end
			endcase
		end
		// 0x3A0001 area feeds the system latch
		strobe.sysLatch = inBitW1;
	end

	// Read region, lane choice is left to the CPU
	always_comb
	begin
		region = mvsPkg::regNone;
		if (bus.rw)
		begin
			case (regionSel)
				mvsPkg::regionIo0: region = mvsPkg::regP1Dip;
				mvsPkg::regionIo1: region = mvsPkg::regStatusA;
				mvsPkg::regionIo2: region = mvsPkg::regP2;
				mvsPkg::regionIo4: region = mvsPkg::regStatusB;
				default: region = mvsPkg::regNone;
			endcase
		end
	end

endmodule

// ==== neoIoPorts.sv ====
`timescale 1ns/1ns

module neoIoPorts (
	input logic clk68k,
	input logic rstN,
	input mvsPkg::busCycle_t bus,
	input mvsPkg::ioStrobe_t strobe,
	input mvsPkg::ioRegion_t region,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic [7:0] dipSw,
	input logic [1:0] coinIn,
	input logic service,
	input logic testBtn,
	output mvsPkg::m68kData_t rdData,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [2:0] cardBank,
	output logic [2:0] slot,
	output logic [7:0] elData,
	output logic [7:0] led1Data,
	output logic [7:0] led2Data
);

	logic [7:0] ledData;
	logic [2:0] ledPrev;
	logic [2:0] ledFell;

	// Latch bits that go from 1 to 0 on this write
	assign ledFell = ledPrev & ~bus.wrData[5:3];

	// Read mux, undriven bytes float high
	always_comb
	begin
		case (region)
			mvsPkg::regP1Dip: rdData = {p1In[7:0], dipSw};
			// Sound byte left out, reads as FF
			mvsPkg::regStatusA: rdData = {8'hFF, 4'hF, testBtn, service, coinIn[1], coinIn[0]};
			mvsPkg::regP2: rdData = {p2In[7:0], 8'hFF};
			// Extra buttons of both players
			mvsPkg::regStatusB: rdData = {p2In[9:8], p1In[9:8], 4'hF, 8'hFF};
			default: rdData = 16'hFFFF;
		endcase
	end

	// Write side, NEO-D0 and NEO-F0 registers
	always_ff @(posedge clk68k)
	begin
		if (!rstN)
		begin
			p1Out <= '0;
			p2Out <= '0;
			cardBank <= '0;
			slot <= '0;
			ledData <= '0;
			// All ones, so the first write of zeros falls on every bit
			ledPrev <= '1;
			elData <= '0;
			led1Data <= '0;
			led2Data <= '0;
		end
		else
		begin
			if (strobe.pOutput)
			begin
				p1Out <= bus.wrData[2:0];
				p2Out <= bus.wrData[5:3];
			end
			if (strobe.crdBank)
				cardBank <= bus.wrData[2:0];
			if (strobe.slot)
				slot <= bus.wrData[2:0];
			if (strobe.ledData)
				ledData <= bus.wrData[7:0];
			if (strobe.ledLatch)
			begin
				// EL panel, then the two LED displays
				if (ledFell[0])
					elData <= ledData;
				if (ledFell[1])
					led1Data <= ledData;
				if (ledFell[2])
					led2Data <= ledData;
				ledPrev <= bus.wrData[5:3];
			end
		end
	end

endmodule

// ==== m68kBusAdapter.sv ====
`timescale 1ns/1ns

module m68kBusAdapter (
	input logic clk68k,
	input logic rstN,
	input logic cpuStb,
	input logic cpuWe,
	input logic [3:0] cpuSel,
	input mvsPkg::cpuAddr_t cpuAddr,
	input logic [31:0] cpuDataOut,
	input mvsPkg::m68kData_t rdData,
	output logic cpuAck,
	output logic [31:0] cpuDataIn,
	output mvsPkg::busCycle_t bus
);

	mvsPkg::adapterState_t state;
	mvsPkg::m68kAddr_t cycAddr;
	mvsPkg::m68kData_t cycData;
	logic cycRw;
	logic cycUds;
	logic cycLds;
	logic isLong;
	logic upperFirst;

	// All four lanes means a longword, split high word first
	assign isLong = &cpuSel;
	// Any upper-half lane starts at A1 = 0
	assign upperFirst = |cpuSel[3:2];

	// Sequencing and ack
	always_ff @(posedge clk68k)
	begin
		if (!rstN)
		begin
			state <= mvsPkg::idle;
			cpuAck <= 1'b0;
		end
		else
		begin
			// Ack is a single pulse
			cpuAck <= 1'b0;
			case (state)
				mvsPkg::idle:
				begin
					if (cpuStb)
						state <= upperFirst ? mvsPkg::hiWord : mvsPkg::loWord;
				end
				mvsPkg::hiWord:
				begin
					if (isLong)
						state <= mvsPkg::loWord;
					else
					begin
						state <= mvsPkg::done;
						cpuAck <= 1'b1;
					end
				end
				mvsPkg::loWord:
				begin
					state <= mvsPkg::done;
					cpuAck <= 1'b1;
				end
				mvsPkg::done:
				begin
					// Hold off until the master drops its strobe
					if (!cpuStb)
						state <= mvsPkg::idle;
				end
			endcase
		end
	end

	// Bus cycle payload and read gathering
	always_ff @(posedge clk68k)
	begin
		case (state)
			mvsPkg::idle:
			begin
				if (cpuStb)
				begin
					cycRw <= ~cpuWe;
					if (upperFirst)
					begin
						cycAddr <= {cpuAddr, 1'b0};
						cycUds <= cpuSel[3];
						cycLds <= cpuSel[2];
						cycData <= cpuDataOut[31:16];
					end
					else
					begin
						cycAddr <= {cpuAddr, 1'b1};
						cycUds <= cpuSel[1];
						cycLds <= cpuSel[0];
						cycData <= cpuDataOut[15:0];
					end
				end
			end
			mvsPkg::hiWord:
			begin
				cpuDataIn[31:16] <= rdData;
				if (isLong)
				begin
					// Second half of a longword
					cycAddr <= {cpuAddr, 1'b1};
					cycUds <= cpuSel[1];
					cycLds <= cpuSel[0];
					cycData <= cpuDataOut[15:0];
				end
				else
					cpuDataIn[15:0] <= '0;
			end
			mvsPkg::loWord:
			begin
				cpuDataIn[15:0] <= rdData;
				if (!isLong)
					cpuDataIn[31:16] <= '0;
			end
			default:
			begin
			end
		endcase
	end

	// Cycle is live only in the two word states
	always_comb
	begin
		bus.valid = (state == mvsPkg::hiWord) || (state == mvsPkg::loWord);
		bus.addr = cycAddr;
		bus.wrData = cycData;
		bus.rw = cycRw;
		bus.uds = cycUds;
		bus.lds = cycLds;
	end

endmodule

// ==== mvsSysIo.sv ====
`timescale 1ns/1ns

module mvsSysIo #(
	parameter int sysLatchBits = 8,
	parameter int coinLatchBits = 4
) (
	input logic clk68k,
	input logic rstN,
	input logic cpuStb,
	input logic cpuWe,
	input logic [3:0] cpuSel,
	input mvsPkg::cpuAddr_t cpuAddr,
	input logic [31:0] cpuDataOut,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic [7:0] dipSw,
	input logic [1:0] coinIn,
	input logic service,
	input logic testBtn,
	output logic cpuAck,
	output logic [31:0] cpuDataIn,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [2:0] cardBank,
	output logic [2:0] slot,
	output logic [7:0] elData,
	output logic [7:0] led1Data,
	output logic [7:0] led2Data,
	output mvsPkg::sysLatch_t sysLatch,
	output mvsPkg::coinCtl_t coinCtl
);

	mvsPkg::busCycle_t bus;
	mvsPkg::ioStrobe_t strobe;
	mvsPkg::ioRegion_t region;
	mvsPkg::m68kData_t rdData;

	// CPU port to 68000 word cycles
	m68kBusAdapter uAdapter (
		.clk68k(clk68k),
		.rstN(rstN),
		.cpuStb(cpuStb),
		.cpuWe(cpuWe),
		.cpuSel(cpuSel),
		.cpuAddr(cpuAddr),
		.cpuDataOut(cpuDataOut),
		.rdData(rdData),
		.cpuAck(cpuAck),
		.cpuDataIn(cpuDataIn),
		.bus(bus)
	);

	// NEO-C1 style I/O decode
	neoAddrDecode uDecode (
		.bus(bus),
		.strobe(strobe),
		.region(region)
	);

	// Inputs, player outputs, card bank, slot, LEDs
	neoIoPorts uPorts (
		.clk68k(clk68k),
		.rstN(rstN),
		.bus(bus),
		.strobe(strobe),
		.region(region),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.coinIn(coinIn),
		.service(service),
		.testBtn(testBtn),
		.rdData(rdData),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.cardBank(cardBank),
		.slot(slot),
		.elData(elData),
		.led1Data(led1Data),
		.led2Data(led2Data)
	);

	// System latch at 0x3A0001
	neoBitLatch #(
		.numBits(sysLatchBits)
	) uSysLatch (
		.clk68k(clk68k),
		.rstN(rstN),
		.wrStb(strobe.sysLatch),
		.addr(bus.addr),
		.q(sysLatch)
	);

	// Coin counters and lockouts, NEO-I0 style
	neoBitLatch #(
		.numBits(coinLatchBits)
	) uCoinLatch (
		.clk68k(clk68k),
		.rstN(rstN),
		.wrStb(strobe.coinLatch),
		.addr(bus.addr),
		.q(coinCtl)
	);

endmodule

// ==== tbMvsSysIo.sv ====
`timescale 1ns/1ns

module tbMvsSysIo;

	// Run length and the cycle budget derived from it
	localparam int numRandom = 300;
	localparam int numDirected = 20;
	localparam int cyclesPerAccess = 7;
	localparam int cycleLimit = (numRandom + numDirected) * cyclesPerAccess * 2 + 20;

	logic clk68k;
	logic rstN;
	logic cpuStb;
	logic cpuWe;
	logic [3:0] cpuSel;
	mvsPkg::cpuAddr_t cpuAddr;
	logic [31:0] cpuDataOut;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic [7:0] dipSw;
	logic [1:0] coinIn;
	logic service;
	logic testBtn;
	logic cpuAck;
	logic [31:0] cpuDataIn;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic [2:0] cardBank;
	logic [2:0] slot;
	logic [7:0] elData;
	logic [7:0] led1Data;
	logic [7:0] led2Data;
	mvsPkg::sysLatch_t sysLatch;
	mvsPkg::coinCtl_t coinCtl;

	// Reference copy of every register and latch
	logic [2:0] mP1Out;
	logic [2:0] mP2Out;
	logic [2:0] mCardBank;
	logic [2:0] mSlot;
	logic [2:0] mLedPrev;
	logic [7:0] mLedData;
	logic [7:0] mEl;
	logic [7:0] mLed1;
	logic [7:0] mLed2;
	logic [7:0] mSys;
	logic [3:0] mCoin;

	int errorCount;
	int checkCount;
	int cycleCount;

	mvsSysIo #(
		.sysLatchBits(8),
		.coinLatchBits(4)
	) u_dut (
		.clk68k(clk68k),
		.rstN(rstN),
		.cpuStb(cpuStb),
		.cpuWe(cpuWe),
		.cpuSel(cpuSel),
		.cpuAddr(cpuAddr),
		.cpuDataOut(cpuDataOut),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.coinIn(coinIn),
		.service(service),
		.testBtn(testBtn),
		.cpuAck(cpuAck),
		.cpuDataIn(cpuDataIn),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.cardBank(cardBank),
		.slot(slot),
		.elData(elData),
		.led1Data(led1Data),
		.led2Data(led2Data),
		.sysLatch(sysLatch),
		.coinCtl(coinCtl)
	);

	// 50 MHz board clock
	always #10 clk68k = ~clk68k;

	// Hang guard
	always @(posedge clk68k)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	begin
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	end
	endtask

	// Word the register map returns for a byte address
	function automatic logic [15:0] readModel(input logic [23:0] byteAddr);
		logic [7:0] area;
		area = {byteAddr[23:17], 1'b0};
		case (area)
			8'h30: readModel = {p1In[7:0], dipSw};
			8'h32: readModel = {8'hFF, 4'b1111, testBtn, service, coinIn[1], coinIn[0]};
			8'h34: readModel = {p2In[7:0], 8'hFF};
			8'h38: readModel = {p2In[9:8], p1In[9:8], 4'b1111, 8'hFF};
			default: readModel = 16'hFFFF;
		endcase
	endfunction

	// One word write into the reference registers
	task automatic applyWrite(input logic [23:0] byteAddr, input logic [15:0] d,
		input logic lowLane);
		logic [7:0] area;
	begin
		area = {byteAddr[23:17], 1'b0};
		if (lowLane && area == 8'h38)
		begin
			case (byteAddr[6:4])
				3'd0:
				begin
					mP1Out = d[2:0];
					mP2Out = d[5:3];
				end
				3'd1: mCardBank = d[2:0];
				3'd2: mSlot = d[2:0];
				3'd3:
				begin
					// Copy on a 1 to 0 transition only
					if (mLedPrev[0] && !d[3])
						mEl = mLedData;
					if (mLedPrev[1] && !d[4])
						mLed1 = mLedData;
					if (mLedPrev[2] && !d[5])
						mLed2 = mLedData;
					mLedPrev = d[5:3];
				end
				3'd4: mLedData = d[7:0];
				3'd6,
				3'd7: mCoin[byteAddr[2:1]] = byteAddr[4];
				default:
				begin
				end
			endcase
		end
		// System latch, bit 4 is the value
		if (lowLane && area == 8'h3A)
			mSys[byteAddr[3:1]] = byteAddr[4];
	end
	endtask

	task automatic checkOutputs();
	begin
		checkValue("p1Out", 32'(mP1Out), 32'(p1Out));
		checkValue("p2Out", 32'(mP2Out), 32'(p2Out));
		checkValue("cardBank", 32'(mCardBank), 32'(cardBank));
		checkValue("slot", 32'(mSlot), 32'(slot));
		checkValue("elData", 32'(mEl), 32'(elData));
		checkValue("led1Data", 32'(mLed1), 32'(led1Data));
		checkValue("led2Data", 32'(mLed2), 32'(led2Data));
		checkValue("sysLatch", 32'(mSys), {24'h0, sysLatch});
		checkValue("coinCtl", 32'(mCoin), {28'h0, coinCtl});
	end
	endtask

	// Full CPU port handshake with model update and checks
	task automatic runAccess(input logic we, input logic [3:0] sel,
		input mvsPkg::cpuAddr_t addr, input logic [31:0] data);
		logic [31:0] rnd;
		logic [31:0] expRead;
		logic [23:0] hiByte;
		logic [23:0] loByte;
		logic ackSeen;
		int waitCount;
		int expWait;
	begin
		rnd = $urandom;
		@(posedge clk68k);
		#2;
		// Fresh panel inputs for every access
		p1In = rnd[9:0];
		p2In = rnd[19:10];
		dipSw = rnd[27:20];
		coinIn = rnd[29:28];
		service = rnd[30];
		testBtn = rnd[31];
		cpuStb = 1'b1;
		cpuWe = we;
		cpuSel = sel;
		cpuAddr = addr;
		cpuDataOut = data;
		hiByte = {addr, 2'b00};
		loByte = {addr, 2'b10};
		if (sel == 4'hF)
		begin
			// Longword goes high word first
			expWait = 3;
			expRead = {readModel(hiByte), readModel(loByte)};
			if (we)
			begin
				applyWrite(hiByte, data[31:16], sel[2]);
				applyWrite(loByte, data[15:0], sel[0]);
			end
		end
		else if (sel[3] || sel[2])
		begin
			expWait = 2;
			expRead = {readModel(hiByte), 16'h0000};
			if (we)
				applyWrite(hiByte, data[31:16], sel[2]);
		end
		else
		begin
			expWait = 2;
			expRead = {16'h0000, readModel(loByte)};
			if (we)
				applyWrite(loByte, data[15:0], sel[0]);
		end
		waitCount = 0;
		ackSeen = 1'b0;
		while (!ackSeen)
		begin
			@(posedge clk68k);
			#1;
			waitCount++;
			ackSeen = cpuAck;
		end
		checkValue("ackDelay", 32'(expWait), 32'(waitCount));
		if (!we)
			checkValue("cpuDataIn", expRead, cpuDataIn);
		checkOutputs();
		// Master drops its strobe the cycle after ack
		#1;
		cpuStb = 1'b0;
		cpuWe = 1'b0;
	end
	endtask

	// Lower lane byte write at any byte address
	task automatic writeByte(input logic [23:0] byteAddr, input logic [7:0] value);
		logic [3:0] sel;
		logic [31:0] data;
	begin
		if (byteAddr[1])
		begin
			sel = 4'b0001;
			data = {24'h0, value};
		end
		else
		begin
			sel = 4'b0100;
			data = {8'h0, value, 16'h0};
		end
		runAccess(1'b1, sel, byteAddr[23:2], data);
	end
	endtask

	task automatic randomAccess();
		logic [31:0] rndA;
		logic [31:0] rndB;
		logic [31:0] data;
		logic [7:0] area;
		logic [1:0] lanes;
		logic [3:0] sel;
	begin
		rndA = $urandom;
		rndB = $urandom;
		data = $urandom;
		// Favor the write areas so the latches see traffic
		case (rndA[2:0])
			3'd0: area = 8'h30;
			3'd1: area = 8'h32;
			3'd2: area = 8'h34;
			3'd3,
			3'd4: area = 8'h38;
			3'd5,
			3'd6: area = 8'h3A;
			default: area = rndB[22:15];
		endcase
		lanes = (rndA[6:5] == 2'b00) ? 2'b11 : rndA[6:5];
		case (rndA[4:3])
			2'd1: sel = {lanes, 2'b00};
			2'd2: sel = {2'b00, lanes};
			default: sel = 4'hF;
		endcase
		runAccess(rndA[7], sel, {area[7:1], rndB[14:0]}, data);
	end
	endtask

	initial
	begin
		// Seed the generator once for the whole run
		void'($urandom(32'h923fb8f5));
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		clk68k = 1'b0;
		rstN = 1'b0;
		cpuStb = 1'b0;
		cpuWe = 1'b0;
		cpuSel = 4'h0;
		cpuAddr = '0;
		cpuDataOut = 32'h0;
		p1In = 10'h0;
		p2In = 10'h0;
		dipSw = 8'h0;
		coinIn = 2'b00;
		service = 1'b0;
		testBtn = 1'b0;
		mP1Out = 3'h0;
		mP2Out = 3'h0;
		mCardBank = 3'h0;
		mSlot = 3'h0;
		mLedPrev = 3'b111;
		mLedData = 8'h00;
		mEl = 8'h00;
		mLed1 = 8'h00;
		mLed2 = 8'h00;
		mSys = 8'h00;
		mCoin = 4'h0;
		repeat (2) @(posedge clk68k);
		#2;
		rstN = 1'b1;

		// Reset state
		checkValue("cpuAck", 32'h0, 32'(cpuAck));
		checkOutputs();

		// First latch write of zeros loads all three LED outputs
		writeByte(24'h380041, 8'h5A);
		writeByte(24'h380031, 8'h00);
		checkValue("elData", 32'h5A, 32'(elData));
		checkValue("led1Data", 32'h5A, 32'(led1Data));
		checkValue("led2Data", 32'h5A, 32'(led2Data));

		// Falling edges one at a time, then none
		writeByte(24'h380031, 8'h38);
		writeByte(24'h380041, 8'h11);
		writeByte(24'h380031, 8'h30);
		writeByte(24'h380041, 8'h22);
		writeByte(24'h380031, 8'h20);
		writeByte(24'h380041, 8'h33);
		writeByte(24'h380031, 8'h00);
		writeByte(24'h380041, 8'h44);
		writeByte(24'h380031, 8'h00);

		// Output, card bank and slot registers
		writeByte(24'h380001, 8'h2B);
		writeByte(24'h380011, 8'h05);
		writeByte(24'h380021, 8'h06);
		// Upper lane and unmapped writes leave state alone
		runAccess(1'b1, 4'b1000, 22'(24'h380000 >> 2), 32'h3F3F_0000);
		writeByte(24'h200001, 8'hFF);

		// Longword halves land at A1 = 0, then A1 = 1
		runAccess(1'b1, 4'hF, 22'(24'h3A0010 >> 2), 32'h0000_0000);
		runAccess(1'b1, 4'hF, 22'(24'h380000 >> 2), 32'h0005_0003);
		runAccess(1'b0, 4'hF, 22'(24'h300000 >> 2), 32'h0000_0000);

		for (int i = 0; i < numRandom; i++)
			randomAccess();

		@(posedge clk68k);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
mvsPkg.sv
neoBitLatch.sv
neoAddrDecode.sv
neoIoPorts.sv
m68kBusAdapter.sv
mvsSysIo.sv
tbMvsSysIo.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing
TOP       = tbMvsSysIo
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
